// ==== blas_engine.sv ====
module blas_engine (
	input	logic					clock,
	input	logic					reset,
	input	blas_pkg::cmd_t			cmd,
	input	logic					cmd_req,
	output	logic					cmd_ack,
	output	blas_pkg::result_t		res,
	output	logic					res_req,
	input	logic					res_ack
);

	blas_pkg::issue_t		issue;
	blas_pkg::lane_res_t	lane_res	[blas_pkg::NUM_LANES];
	logic					res_done;

	////////////////////
	// Command issue
	issue_unit issue_unit_inst (
		.clock		(clock),
		.reset		(reset),
		.cmd		(cmd),
		.cmd_req	(cmd_req),
		.cmd_ack	(cmd_ack),
		.res_done	(res_done),
		.issue		(issue)
	);

	////////////////////
	// Lane row
	for (genvar i = 0; i < blas_pkg::NUM_LANES; i++) begin : g_lane
		lane_unit #(
			.LANE		(i)
		) lane_unit_inst (
			.clock		(clock),
			.reset		(reset),
			.issue		(issue),
			.lane_res	(lane_res[i])
		);
	end

	////////////////////
	// Reduction and return
	commit_agg commit_agg_inst (
		.clock		(clock),
		.reset		(reset),
		.issue		(issue),
		.lane_res	(lane_res),
		.res		(res),
		.res_req	(res_req),
		.res_ack	(res_ack),
		.res_done	(res_done)
	);

endmodule

// ==== blas_pkg.sv ====
package blas_pkg;

	////////////////////
	// Sizes
	localparam int NUM_LANES	= 4;
	localparam int MEM_WORDS	= 8;
	localparam int ADDR_W		= $clog2(MEM_WORDS);
	localparam int DATA_W		= 16;
	localparam int ISSUE_W		= 4;

	// Queue depths, result depth doubles as credit limit
	localparam int CMD_DEPTH	= 4;
	localparam int RES_DEPTH	= 4;
	localparam int CREDIT_W		= $clog2(RES_DEPTH + 1);

	////////////////////
	// Scalar types
	typedef enum logic [1:0] {
		OP_WRITE	= 2'd0,		// mem[dst] = imm
		OP_AXPY		= 2'd1,		// mem[dst] += imm * mem[src]
		OP_READ		= 2'd2		// Return mem[src]
	} opcode_t;

	typedef logic [NUM_LANES-1:0]	lane_mask_t;
	typedef logic [ADDR_W-1:0]		addr_t;
	typedef logic [DATA_W-1:0]		data_t;
	typedef logic [ISSUE_W-1:0]		issue_no_t;

	////////////////////
	// Host command
	typedef struct packed {
		opcode_t		opcode;
		addr_t			dst;
		addr_t			src;
		data_t			imm;
		lane_mask_t		mask;
	} cmd_t;

	// Broadcast to all lanes
	typedef struct packed {
		logic			valid;
		issue_no_t		issue_no;
		cmd_t			cmd;
	} issue_t;

	// Per-lane output
	typedef struct packed {
		logic			valid;
		issue_no_t		issue_no;
		data_t			value;
	} lane_res_t;

	////////////////////
	// Back to host
	typedef struct packed {
		issue_no_t		issue_no;
		opcode_t		opcode;
		data_t			value;
	} result_t;

endpackage

// ==== commit_agg.sv ====
module commit_agg (
	input	logic					clock,
	input	logic					reset,
	input	blas_pkg::issue_t		issue,
	input	blas_pkg::lane_res_t	lane_res	[blas_pkg::NUM_LANES],
	output	blas_pkg::result_t		res,
	output	logic					res_req,
	input	logic					res_ack,
	output	logic					res_done
);

	typedef struct packed {
		logic					valid;
		blas_pkg::issue_no_t	issue_no;
		blas_pkg::opcode_t		opcode;
		blas_pkg::lane_mask_t	mask;
	} tag_t;

	typedef enum logic [1:0] {
		SEND_IDLE,
		SEND_REQ,
		SEND_ACKED
	} send_state_t;

	tag_t					tag_d1;
	tag_t					tag_d2;
	blas_pkg::data_t		lane_sum;
	blas_pkg::result_t		new_res;
	logic					q_push;
	logic					q_pop;
	logic					q_empty;
	send_state_t			send_state;

	////////////////////
	// Align with lane stage 2
	always_ff @(posedge clock) begin
		if (reset) begin
			tag_d1.valid	<= 1'b0;
			tag_d2.valid	<= 1'b0;
		end else begin
			tag_d1.valid	<= issue.valid;
			tag_d1.issue_no	<= issue.issue_no;
			tag_d1.opcode	<= issue.cmd.opcode;
			tag_d1.mask		<= issue.cmd.mask;
			tag_d2			<= tag_d1;
		end
	end

	// Wraps at DATA_W, empty mask sums to 0
	always_comb begin
		lane_sum = '0;
		for (int i = 0; i < blas_pkg::NUM_LANES; i++) begin
			if (lane_res[i].valid) begin
				lane_sum = lane_sum + lane_res[i].value;
			end
		end
	end

	assign new_res	= '{issue_no: tag_d2.issue_no, opcode: tag_d2.opcode, value: lane_sum};
	assign q_push	= tag_d2.valid;		// Credits keep the queue from filling

	sync_fifo #(
		.payload_t	(blas_pkg::result_t),
		.DEPTH		(blas_pkg::RES_DEPTH)
	) res_fifo (
		.clock		(clock),
		.reset		(reset),
		.push		(q_push),
		.din		(new_res),
		.pop		(q_pop),
		.dout		(res),
		.full		(),
		.empty		(q_empty)
	);

	////////////////////
	// Four-phase send
	assign res_req	= (send_state == SEND_REQ);
	assign q_pop	= (send_state == SEND_ACKED) && !res_ack;

	always_ff @(posedge clock) begin
		if (reset) begin
			send_state	<= SEND_IDLE;
			res_done	<= 1'b0;
		end else begin
			res_done <= q_pop;		// One credit back
			case (send_state)
				SEND_IDLE: begin
					if (!q_empty) begin
						send_state <= SEND_REQ;
					end
				end
				SEND_REQ: begin
					if (res_ack) begin
						send_state <= SEND_ACKED;
					end
				end
				SEND_ACKED: begin
					if (!res_ack) begin
						send_state <= SEND_IDLE;
					end
				end
				default:	send_state <= SEND_IDLE;
			endcase
		end
	end

	for (genvar i = 0; i < blas_pkg::NUM_LANES; i++) begin : g_lane_chk
		lane_tag_a: assert property (@(posedge clock) disable iff (reset)
			lane_res[i].valid |-> tag_d2.valid && tag_d2.mask[i]
				&& (lane_res[i].issue_no == tag_d2.issue_no));
	end

	ack_proto_a: assert property (@(posedge clock) disable iff (reset)
		$rose(res_ack) |-> res_req);

endmodule

// ==== issue_unit.sv ====
module issue_unit (
	input	logic					clock,
	input	logic					reset,
	input	blas_pkg::cmd_t			cmd,
	input	logic					cmd_req,
	output	logic					cmd_ack,
	input	logic					res_done,
	output	blas_pkg::issue_t		issue
);

	logic								q_push;
	logic								q_pop;
	logic								q_full;
	logic								q_empty;
	blas_pkg::cmd_t						q_head;
	blas_pkg::issue_no_t				issue_cnt;
	logic	[blas_pkg::CREDIT_W-1:0]	outstanding;

	////////////////////
	// Four-phase receive
	assign q_push = cmd_req && !cmd_ack && !q_full;		// Full queue holds off ack

	always_ff @(posedge clock) begin
		if (reset) begin
			cmd_ack <= 1'b0;
		end else if (q_push) begin
			cmd_ack <= 1'b1;
		end else if (cmd_ack && !cmd_req) begin
			cmd_ack <= 1'b0;
		end
	end

	sync_fifo #(
		.payload_t	(blas_pkg::cmd_t),
		.DEPTH		(blas_pkg::CMD_DEPTH)
	) cmd_fifo (
		.clock		(clock),
		.reset		(reset),
		.push		(q_push),
		.din		(cmd),
		.pop		(q_pop),
		.dout		(q_head),
		.full		(q_full),
		.empty		(q_empty)
	);

	////////////////////
	// Issue and credits
	assign q_pop = !q_empty && (outstanding < blas_pkg::RES_DEPTH);

	always_ff @(posedge clock) begin
		if (reset) begin
			outstanding <= '0;
		end else begin
			case ({q_pop, res_done})
				2'b10:		outstanding <= outstanding + 1'b1;
				2'b01:		outstanding <= outstanding - 1'b1;
				default:	outstanding <= outstanding;
			endcase
		end
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			issue.valid	<= 1'b0;
			issue_cnt	<= '0;
		end else begin
			issue.valid <= q_pop;		// Single cycle pulse
			if (q_pop) begin
				issue.issue_no	<= issue_cnt;
				issue.cmd		<= q_head;
				issue_cnt		<= issue_cnt + 1'b1;
			end
		end
	end

	credit_limit_a: assert property (@(posedge clock) disable iff (reset)
		outstanding <= blas_pkg::RES_DEPTH);

	// Commit side never returns more than was issued
	done_balance_a: assert property (@(posedge clock) disable iff (reset)
		res_done |-> outstanding != '0);

endmodule

// ==== lane_unit.sv ====
module lane_unit #(
	parameter int LANE = 0
)(
	input	logic					clock,
	input	logic					reset,
	input	blas_pkg::issue_t		issue,
	output	blas_pkg::lane_res_t	lane_res
);

	typedef struct packed {
		logic					valid;
		blas_pkg::issue_no_t	issue_no;
		blas_pkg::opcode_t		opcode;
		blas_pkg::addr_t		dst;
		blas_pkg::data_t		imm;
		blas_pkg::data_t		src_val;
		blas_pkg::data_t		dst_val;
	} stage_t;

	blas_pkg::data_t					mem	[blas_pkg::MEM_WORDS];
	stage_t								s1;
	logic								hit;
	blas_pkg::data_t					src_rd;
	blas_pkg::data_t					dst_rd;
	logic	[2*blas_pkg::DATA_W-1:0]	product;
	blas_pkg::data_t					s2_value;
	logic								s2_write;

	assign hit = issue.valid && issue.cmd.mask[LANE];

	////////////////////
	// Stage 1 operand read
	// Bypass the write that stage 2 retires on this edge
	assign src_rd = (s2_write && (s1.dst == issue.cmd.src)) ? s2_value
		: mem[issue.cmd.src];
	assign dst_rd = (s2_write && (s1.dst == issue.cmd.dst)) ? s2_value
		: mem[issue.cmd.dst];

	always_ff @(posedge clock) begin
		if (reset) begin
			s1.valid <= 1'b0;
		end else begin
			s1.valid <= hit;
			if (hit) begin
				s1.issue_no	<= issue.issue_no;
				s1.opcode	<= issue.cmd.opcode;
				s1.dst		<= issue.cmd.dst;
				s1.imm		<= issue.cmd.imm;
				s1.src_val	<= src_rd;
				s1.dst_val	<= dst_rd;
			end
		end
	end

	////////////////////
	// Stage 2 execute
	assign product = s1.imm * s1.src_val;

	always_comb begin
		case (s1.opcode)
			blas_pkg::OP_WRITE:	s2_value = s1.imm;
			blas_pkg::OP_AXPY:	s2_value = s1.dst_val + product[blas_pkg::DATA_W-1:0];
			default:			s2_value = s1.src_val;		// READ
		endcase
	end

	assign s2_write = s1.valid && (s1.opcode != blas_pkg::OP_READ);

	always_ff @(posedge clock) begin
		if (reset) begin
			for (int i = 0; i < blas_pkg::MEM_WORDS; i++) begin
				mem[i] <= '0;
			end
		end else if (s2_write) begin
			mem[s1.dst] <= s2_value;
		end
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			lane_res.valid <= 1'b0;
		end else begin
			lane_res.valid <= s1.valid;
			if (s1.valid) begin
				lane_res.issue_no	<= s1.issue_no;
				lane_res.value		<= s2_value;		// Written or read value
			end
		end
	end

endmodule

// ==== sync_fifo.sv ====
module sync_fifo #(
	parameter type	payload_t	= logic,
	parameter int	DEPTH		= 4
)(
	input	logic		clock,
	input	logic		reset,
	input	logic		push,
	input	payload_t	din,
	input	logic		pop,
	output	payload_t	dout,
	output	logic		full,
	output	logic		empty
);

	localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;

	payload_t				buffer	[DEPTH];
	logic	[PTR_W-1:0]		wr_ptr;
	logic	[PTR_W-1:0]		rd_ptr;
	logic	[PTR_W-1:0]		wr_next;
	logic	[PTR_W-1:0]		rd_next;
	logic	[PTR_W:0]		count;

	// Wrap for non power of two depths
	assign wr_next	= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
	assign rd_next	= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;

	assign full		= (count == DEPTH);
	assign empty	= (count == '0);
	assign dout		= buffer[rd_ptr];		// Head, no read latency

	always_ff @(posedge clock) begin
		if (push) begin
			buffer[wr_ptr] <= din;
		end
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			wr_ptr	<= '0;
			rd_ptr	<= '0;
			count	<= '0;
		end else begin
			if (push) begin
				wr_ptr <= wr_next;
			end
			if (pop) begin
				rd_ptr <= rd_next;
			end
			case ({push, pop})
				2'b10:		count <= count + 1'b1;
				2'b01:		count <= count - 1'b1;
				default:	count <= count;
			endcase
		end
	end

	no_overflow_a: assert property (@(posedge clock) disable iff (reset)
		!(push && full));
	no_underflow_a: assert property (@(posedge clock) disable iff (reset)
		!(pop && empty));

endmodule

// ==== tb_blas_engine.sv ====
module tb_blas_engine;

	logic					clock = 1'b0;
	logic					reset;
	blas_pkg::cmd_t			cmd;
	logic					cmd_req;
	logic					cmd_ack;
	blas_pkg::result_t		res;
	logic					res_req;
	logic					res_ack;

	string					names[$];
	blas_pkg::cmd_t			cmds[$];
	blas_pkg::result_t		exps[$];
	int						ack_delays[$];		// Host ack delay per result, 0 to 6 cycles
	blas_pkg::data_t		model_mem	[blas_pkg::NUM_LANES][blas_pkg::MEM_WORDS];
	int						num_tests		= 0;
	int						timeout_limit	= 0;
	int						cycle_count		= 0;
	logic					rx_start		= 1'b0;

	blas_engine blas_engine_inst (
		.clock		(clock),
		.reset		(reset),
		.cmd		(cmd),
		.cmd_req	(cmd_req),
		.cmd_ack	(cmd_ack),
		.res		(res),
		.res_req	(res_req),
		.res_ack	(res_ack)
	);

	always #50 clock = ~clock;

	////////////////////
	// Table and reference model
	task automatic add_entry(input string name, input blas_pkg::opcode_t op,
		input blas_pkg::addr_t dst, input blas_pkg::addr_t src,
		input blas_pkg::data_t imm, input blas_pkg::lane_mask_t mask);
		blas_pkg::cmd_t		c;
		blas_pkg::result_t	r;
		blas_pkg::data_t	v;
		blas_pkg::data_t	sum;
		sum = '0;
		for (int l = 0; l < blas_pkg::NUM_LANES; l++) begin
			if (mask[l]) begin
				case (op)
					blas_pkg::OP_WRITE:	v = imm;
					blas_pkg::OP_AXPY:	v = model_mem[l][dst] + imm * model_mem[l][src];
					default:			v = model_mem[l][src];
				endcase
				if (op != blas_pkg::OP_READ) begin
					model_mem[l][dst] = v;		// Later entries see this
				end
				sum = sum + v;
			end
		end
		c = '{opcode: op, dst: dst, src: src, imm: imm, mask: mask};
		r = '{issue_no: blas_pkg::issue_no_t'(names.size() % 16), opcode: op, value: sum};
		names.push_back(name);
		cmds.push_back(c);
		exps.push_back(r);
		ack_delays.push_back($urandom % 7);
	endtask

	task automatic build_table();
		for (int l = 0; l < blas_pkg::NUM_LANES; l++) begin
			for (int w = 0; w < blas_pkg::MEM_WORDS; w++) begin
				model_mem[l][w] = '0;
			end
		end
		add_entry("write_full",   blas_pkg::OP_WRITE, 3'd0, 3'd0, 16'h0005, 4'hf);
		add_entry("read_full",    blas_pkg::OP_READ,  3'd0, 3'd0, 16'h0000, 4'hf);
		add_entry("write_x",      blas_pkg::OP_WRITE, 3'd1, 3'd0, 16'h0003, 4'hf);
		add_entry("write_y",      blas_pkg::OP_WRITE, 3'd2, 3'd0, 16'h0007, 4'hf);
		add_entry("axpy_fwd",     blas_pkg::OP_AXPY,  3'd2, 3'd1, 16'h0004, 4'hf);
		add_entry("axpy_again",   blas_pkg::OP_AXPY,  3'd2, 3'd1, 16'h0002, 4'hf);
		add_entry("read_y",       blas_pkg::OP_READ,  3'd0, 3'd2, 16'h0000, 4'hf);
		add_entry("write_big",    blas_pkg::OP_WRITE, 3'd3, 3'd0, 16'h7fff, 4'hf);
		add_entry("axpy_wrap",    blas_pkg::OP_AXPY,  3'd3, 3'd3, 16'h1234, 4'hf);
		add_entry("read_wrap",    blas_pkg::OP_READ,  3'd0, 3'd3, 16'h0000, 4'hf);
		// Partial masks
		add_entry("write_lane0",  blas_pkg::OP_WRITE, 3'd4, 3'd0, 16'h0011, 4'h1);
		add_entry("write_lane2",  blas_pkg::OP_WRITE, 3'd4, 3'd0, 16'h0100, 4'h4);
		add_entry("axpy_odd",     blas_pkg::OP_AXPY,  3'd4, 3'd1, 16'h0009, 4'ha);
		add_entry("read_part",    blas_pkg::OP_READ,  3'd0, 3'd4, 16'h0000, 4'hf);
		add_entry("zero_mask_wr", blas_pkg::OP_WRITE, 3'd5, 3'd0, 16'hbeef, 4'h0);
		add_entry("zero_mask_rd", blas_pkg::OP_READ,  3'd0, 3'd0, 16'h0000, 4'h0);
		add_entry("read_unset",   blas_pkg::OP_READ,  3'd0, 3'd5, 16'h0000, 4'hf);
		// Random immediates
		add_entry("write_rand_a", blas_pkg::OP_WRITE, 3'd6, 3'd0,
			blas_pkg::data_t'($urandom), 4'hf);
		add_entry("write_rand_b", blas_pkg::OP_WRITE, 3'd7, 3'd0,
			blas_pkg::data_t'($urandom), 4'h6);
		add_entry("axpy_rand",    blas_pkg::OP_AXPY,  3'd6, 3'd7,
			blas_pkg::data_t'($urandom), 4'hf);
		add_entry("axpy_self",    blas_pkg::OP_AXPY,  3'd7, 3'd7,
			blas_pkg::data_t'($urandom), 4'h9);
		add_entry("read_rand_a",  blas_pkg::OP_READ,  3'd0, 3'd6, 16'h0000, 4'hf);
		add_entry("read_rand_b",  blas_pkg::OP_READ,  3'd0, 3'd7, 16'h0000, 4'h3);
		add_entry("read_y_lane3", blas_pkg::OP_READ,  3'd0, 3'd2, 16'h0000, 4'h8);
		add_entry("read_last",    blas_pkg::OP_READ,  3'd0, 3'd3, 16'h0000, 4'hf);
	endtask

	////////////////////
	// Checks
	task automatic check_result(input string name, input blas_pkg::result_t exp,
		input blas_pkg::result_t act);
		if (act !== exp) begin
			$display("Error: %s expected issue %0d op %0d value %h, actual issue %0d op %0d value %h",
				name, exp.issue_no, exp.opcode, exp.value,
				act.issue_no, act.opcode, act.value);
			$display("Test failures found");
			$fatal(1);
		end
	endtask

	task automatic check_level(input string name, input logic exp, input logic act);
		if (act !== exp) begin
			$display("Error: %s expected %b actual %b", name, exp, act);
			$display("Test failures found");
			$fatal(1);
		end
	endtask

	always @(posedge clock) begin
		cycle_count <= cycle_count + 1;
		if (timeout_limit > 0 && cycle_count >= timeout_limit) begin
			$display("Timeout after %0d cycles, results stopped arriving", cycle_count);
			$display("Test failures found");
			$fatal(1);
		end
	end

	////////////////////
	// Host sender
	initial begin
		reset	= 1'b1;
		cmd		= '0;
		cmd_req	= 1'b0;
		res_ack	= 1'b0;
		void'($urandom(32344));
		build_table();
		num_tests		= names.size();
		timeout_limit	= num_tests * 40;
		repeat (10) @(posedge clock);
		reset <= 1'b0;
		@(posedge clock);
		@(posedge clock);
		check_level("reset_cmd_ack", 1'b0, cmd_ack);
		check_level("reset_res_req", 1'b0, res_req);
		rx_start = 1'b1;
		for (int i = 0; i < num_tests; i++) begin
			cmd		<= cmds[i];
			cmd_req	<= 1'b1;
			while (!cmd_ack) @(posedge clock);		// Full queue stalls here
			cmd_req	<= 1'b0;
			while (cmd_ack) @(posedge clock);
		end
	end

	////////////////////
	// Host receiver
	initial begin
		wait (rx_start);
		for (int i = 0; i < num_tests; i++) begin
			while (!res_req) @(posedge clock);
			check_result(names[i], exps[i], res);
			repeat (ack_delays[i]) @(posedge clock);
			res_ack <= 1'b1;
			@(posedge clock);
			while (res_req) @(posedge clock);
			res_ack <= 1'b0;
			@(posedge clock);
		end
		// Nothing more may follow the last entry
		repeat (20) begin
			@(posedge clock);
			if (res_req) begin
				$display("Extra result arrived after the last command, issue %0d",
					res.issue_no);
				$display("Test failures found");
				$fatal(1);
			end
		end
		$display("All tests passed!");
		$finish;
	end

endmodule

// ==== vlog.f ====
blas_pkg.sv
sync_fifo.sv
issue_unit.sv
lane_unit.sv
commit_agg.sv
blas_engine.sv
tb_blas_engine.sv
